/* Makefile */
# Verilator build and run of the spram_sys testbench
TOP = tb_spram_sys

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f build.f --top-module $(TOP) -Mdir obj_dir

# the log decides pass or fail
run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* build.f */
verilog/spram_pkg.sv
verilog/spram_bank.sv
verilog/spram.sv
verilog/sync_fifo.sv
verilog/mem_ctrl.sv
verilog/spram_sys.sv
dv/spram_sys_checker.sv
dv/tb_spram_sys.sv

/* dv/spram_patterns.txt */
# columns: op addr mask wdata expect, all hex; op 1 is a write, op 0 a read
# op f starts a test: addr holds the test number, mask 1 withholds response credits
f 1 0 0 0
1 05 ffffffff deadbeef 0
0 05 0 0 deadbeef
1 2a ffffffff 01234567 0
0 2a 0 0 01234567
f 2 0 0 0
1 10 ffffffff aaaaaaaa 0
1 10 0000ffff 12345678 0
0 10 0 0 aaaa5678
1 11 ffffffff 12121212 0
1 11 f0f0f0f0 5a5a5a5a 0
0 11 0 0 52525252
f 3 0 0 0
1 03 ffffffff 0000b000 0
1 43 ffffffff 1111b111 0
1 83 ffffffff 2222b222 0
1 c3 ffffffff 3333b333 0
1 43 0000ffff 00004444 0
0 03 0 0 0000b000
0 43 0 0 11114444
0 83 0 0 2222b222
0 c3 0 0 3333b333
f 4 0 0 0
1 20 ffffffff 00000020 0
1 60 ffffffff 00000060 0
0 20 0 0 00000020
1 20 ff000000 ab000000 0
0 20 0 0 ab000020
0 60 0 0 00000060
1 a0 ffffffff cafef00d 0
0 a0 0 0 cafef00d
0 05 0 0 deadbeef
f 5 1 0 0
0 05 0 0 deadbeef
0 2a 0 0 01234567
0 10 0 0 aaaa5678
0 11 0 0 52525252
0 03 0 0 0000b000
0 43 0 0 11114444
0 83 0 0 2222b222
0 c3 0 0 3333b333
0 20 0 0 ab000020
0 60 0 0 00000060
0 a0 0 0 cafef00d

/* dv/spram_sys_checker.sv */
// concurrent assertions for queue overflow and underflow, response credits and unknown data
module spram_sys_checker #(
    parameter int width   = 1,
    parameter int credits = 0
) (
    input logic             clk,
    input logic             arst_n,
    input logic             push,
    input logic             pop,
    input logic             full,
    input logic             empty,
    input logic [width-1:0] data,          // queue head while popped
    input logic             valid,         // response strobe toward the consumer
    input logic             credit_return  // consumer hands back one credit
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;
    int held_credits;  // granted by the consumer, not yet spent

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            held_credits <= credits;
        end else begin
            held_credits <= held_credits + int'(credit_return) - int'(valid);
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n) push |-> !full)
        else begin
            $error("push into a full queue");
            fail_count++;
        end

    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty)
        else begin
            $error("pop from an empty queue");
            fail_count++;
        end

    // on the response queue this is rsp_data while rsp_valid
    a_data_known: assert property (@(posedge clk) disable iff (!arst_n) pop |-> !$isunknown(data))
        else begin
            $error("unknown data at the head of a popped queue");
            fail_count++;
        end

    a_credit_held: assert property (@(posedge clk) disable iff (!arst_n)
                                    valid |-> held_credits > 0)
        else begin
            $error("rsp_valid with no response credit held");
            fail_count++;
        end

endmodule

bind sync_fifo spram_sys_checker #(.width(width)) u_fifo_chk (
    .clk           (clk),
    .arst_n        (arst_n),
    .push          (push),
    .pop           (pop),
    .full          (full),
    .empty         (empty),
    .data          (pop_data),
    .valid         (1'b0),
    .credit_return (1'b0)
);

bind mem_ctrl spram_sys_checker #(.credits(rsp_credits)) u_ctrl_chk (
    .clk           (clk),
    .arst_n        (arst_n),
    .push          (1'b0),
    .pop           (1'b0),
    .full          (1'b0),
    .empty         (1'b0),
    .data          (1'b0),
    .valid         (rsp_valid),
    .credit_return (rsp_credit)
);

/* dv/tb_spram_sys.sv */
// testbench for spram_sys with pattern driven requests, credit flow on both sides and response checks
module tb_spram_sys;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int req_depth   = 4;    // dut defaults
    localparam int rsp_credits = 2;
    localparam int max_cmds    = 64;
    localparam int max_tests   = 8;
    localparam int send_limit  = 200;  // cycles waiting for one request credit
    localparam int rsp_limit   = 200;  // cycles without response progress
    localparam int hold_window = 30;   // cycles watched while credits are withheld

    logic             clk;
    logic             arst_n;
    logic             req_valid;
    logic             req_we;
    spram_pkg::addr_t req_addr;
    spram_pkg::data_t req_wmask;
    spram_pkg::data_t req_wdata;
    logic             rsp_credit;
    logic             req_credit;
    logic             rsp_valid;
    spram_pkg::data_t rsp_data;

    logic [3:0]       c_op   [max_cmds];  // 1 write, 0 read
    spram_pkg::addr_t c_addr [max_cmds];
    spram_pkg::data_t c_mask [max_cmds];
    spram_pkg::data_t c_data [max_cmds];
    spram_pkg::data_t c_exp  [max_cmds];
    int               t_num   [max_tests];
    int               t_first [max_tests];
    int               t_end   [max_tests];  // one past the last command
    logic             t_hold  [max_tests];
    spram_pkg::data_t shadow    [256];
    logic             shadow_ok [256];
    int               n_cmds;
    int               n_tests;
    int               sent_total     = 0;
    int               returned_total = 0;
    int               errors;
    int               checks;
    int               seed;
    logic             abort;

    spram_sys dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req_we     (req_we),
        .req_addr   (req_addr),
        .req_wmask  (req_wmask),
        .req_wdata  (req_wdata),
        .rsp_credit (rsp_credit),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data)
    );

    always #20 clk = ~clk;

    // request credits coming back, sampled mid cycle
    always @(negedge clk) begin
        if (req_credit) begin
            returned_total = returned_total + 1;
            if (returned_total > sent_total) begin
                $display("req_credit returned with no request outstanding");
                errors++;
            end
        end
    end

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        logic [3:0]  op;
        logic [7:0]  a;
        logic [31:0] m;
        logic [31:0] d;
        logic [31:0] e;
        for (int i = 0; i < 256; i++) begin
            shadow_ok[i] = 1'b0;
        end
        n_cmds  = 0;
        n_tests = 0;
        fd = $fopen("dv/spram_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open the pattern file dv/spram_patterns.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && n_cmds < max_cmds && n_tests < max_tests) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h", op, a, m, d, e);
                if (n != 5) begin
                    $display("malformed pattern line: %s", line);
                    errors++;
                end else if (op == 4'hf) begin  // test marker
                    if (n_tests > 0) t_end[n_tests-1] = n_cmds;
                    t_num[n_tests]   = int'(a);
                    t_first[n_tests] = n_cmds;
                    t_hold[n_tests]  = m[0];
                    n_tests++;
                end else begin
                    c_op[n_cmds]   = op;
                    c_addr[n_cmds] = a;
                    c_mask[n_cmds] = m;
                    c_data[n_cmds] = d;
                    if (op == 4'h1) begin
                        shadow[a]    = (shadow[a] & ~m) | (d & m);  // masked bits only
                        shadow_ok[a] = 1'b1;
                    end else if (!shadow_ok[a] || shadow[a] !== e) begin
                        $display("pattern expects %h at address %h but its writes give %h",
                                 e, a, shadow[a]);
                        errors++;
                    end
                    c_exp[n_cmds] = shadow[a];
                    n_cmds++;
                end
            end
        end
        if (n_tests > 0) t_end[n_tests-1] = n_cmds;
        $fclose(fd);
    endtask

    task automatic send_cmds(input int t);
        int i;
        int wait_cycles;
        i = t_first[t];
        wait_cycles = 0;
        while (i < t_end[t] && !abort) begin
            @(posedge clk);
            #2;
            if (req_depth - (sent_total - returned_total) > 0) begin
                req_valid = 1'b1;
                req_we    = c_op[i][0];
                req_addr  = c_addr[i];
                req_wmask = c_mask[i];
                req_wdata = c_data[i];
                sent_total++;
                i++;
                wait_cycles = 0;
            end else begin
                req_valid = 1'b0;  // out of credits
                wait_cycles++;
                if (wait_cycles > send_limit) begin
                    $display("timeout: no request credit came back in %0d cycles", send_limit);
                    errors++;
                    abort = 1'b1;
                end
            end
        end
        @(posedge clk);
        #2;
        req_valid = 1'b0;
    endtask

    task automatic take_rsps(input int t, input int reads);
        int   seen;
        int   pending;  // credits owed back to the dut
        int   gap;
        int   idle;
        int   held;
        int   i;
        logic give_back;
        seen      = 0;
        pending   = 0;
        gap       = 0;
        idle      = 0;
        held      = 0;
        i         = t_first[t];
        give_back = !t_hold[t];
        while ((seen < reads || pending > 0) && !abort) begin
            @(negedge clk);
            idle++;
            if (rsp_valid) begin
                while (i < t_end[t] && c_op[i] != 4'h0) i++;
                checks++;
                if (i >= t_end[t]) begin
                    $display("response arrived with no read left to match it");
                    errors++;
                end else if (rsp_data !== c_exp[i]) begin
                    $display("mismatch rsp_data at address %h: got %h, expected %h",
                             c_addr[i], rsp_data, c_exp[i]);
                    errors++;
                end
                i++;
                seen++;
                pending++;
                idle = 0;
                if (!give_back && seen > rsp_credits) begin
                    $display("response sent while all response credits were withheld");
                    errors++;
                end
            end
            @(posedge clk);
            #2;
            if (!give_back && seen >= rsp_credits) begin
                held++;
                if (held >= hold_window) begin
                    give_back = 1'b1;
                    checks++;
                    if (sent_total - returned_total != req_depth) begin
                        $display("requester still held credits under response back-pressure");
                        errors++;
                    end
                end
            end
            if (give_back && pending > 0 && gap == 0) begin
                rsp_credit = 1'b1;
                pending--;
                gap = $random(seed) & 3;  // random spacing between credits
            end else begin
                rsp_credit = 1'b0;
                if (gap > 0) gap--;
            end
            if (idle > rsp_limit) begin
                $display("timeout: %0d of %0d responses after %0d idle cycles", seen, reads, idle);
                errors++;
                abort = 1'b1;
            end
        end
        @(posedge clk);
        #2;
        rsp_credit = 1'b0;
    endtask

    task automatic run_test(input int t);
        int errs_before;
        int reads;
        errs_before = errors;
        reads = 0;
        for (int i = t_first[t]; i < t_end[t]; i++) begin
            if (c_op[i] == 4'h0) reads++;
        end
        fork
            send_cmds(t);
            take_rsps(t, reads);
        join
        $display("test %0d: %0d commands, %0d reads, %0d errors", t_num[t],
                 t_end[t] - t_first[t], reads, errors - errs_before);
    endtask

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        req_valid  = 1'b0;
        req_we     = 1'b0;
        req_addr   = '0;
        req_wmask  = '0;
        req_wdata  = '0;
        rsp_credit = 1'b0;
        seed       = 69;
        errors     = 0;
        checks     = 0;
        abort      = 1'b0;
        load_patterns();
        if (n_tests == 0) begin
            $display("no tests found in the pattern file");
            errors++;
        end
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;
        for (int t = 0; t < n_tests && !abort; t++) begin
            run_test(t);
        end
        // assertion failures in the bound checkers
        errors = errors + dut.u_req_fifo.u_fifo_chk.fail_count
                        + dut.u_rsp_fifo.u_fifo_chk.fail_count
                        + dut.u_ctrl.u_ctrl_chk.fail_count;
        $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
        if (errors == 0 && !abort) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* verilog/mem_ctrl.sv */
// issue control, request credit return and response credit tracking
module mem_ctrl #(
    parameter int rsp_depth   = 4,
    parameter int rsp_credits = 2
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic [spram_pkg::req_w-1:0]    head,       // request queue head
    input  logic                           req_empty,
    input  logic [$clog2(rsp_depth+1)-1:0] rsp_count,
    input  logic                           rsp_empty,
    input  logic                           rsp_credit,  // consumer returns one credit
    output logic                           req_pop,
    output logic                           req_credit,
    output logic                           mem_ce,
    output logic                           mem_we,
    output spram_pkg::addr_t               mem_addr,
    output spram_pkg::data_t               mem_wmask,
    output spram_pkg::data_t               mem_din,
    output logic                           rsp_push,
    output logic                           rsp_pop,
    output logic                           rsp_valid
);

    localparam int dw    = spram_pkg::dw;
    localparam int aw    = spram_pkg::aw;
    localparam int req_w = spram_pkg::req_w;
    localparam int crd_w = $clog2(rsp_credits + 1);

    logic             head_we;
    logic             rsp_room;     // a read issued now has a slot
    logic             issue;
    logic             rd_inflight;  // read data lands on dout next cycle
    logic [crd_w-1:0] credit_cnt;

    // unpack head entry: we, addr, wmask, wdata
    assign head_we   = head[req_w-1];
    assign mem_addr  = head[req_w-2 -: aw];
    assign mem_wmask = head[2*dw-1 -: dw];
    assign mem_din   = head[dw-1:0];

    // the read in flight already owns a slot in the response queue
    assign rsp_room = (int'(rsp_count) + int'(rd_inflight)) < rsp_depth;

    // writes never need response space
    assign issue   = !req_empty && (head_we || rsp_room);
    assign req_pop = issue;
    assign mem_ce  = issue;
    assign mem_we  = issue && head_we;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_inflight <= 1'b0;
            req_credit  <= 1'b0;
        end else begin
            rd_inflight <= issue && !head_we;
            req_credit  <= issue;  // one credit per popped entry
        end
    end

    assign rsp_push = rd_inflight;  // dout is valid this cycle

    // response side: send only while a consumer credit is held
    assign rsp_pop   = !rsp_empty && (credit_cnt != '0);
    assign rsp_valid = rsp_pop;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt <= crd_w'(rsp_credits);
        end else begin
            case ({rsp_credit, rsp_valid})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;  // none, or return and spend
            endcase
        end
    end

endmodule

/* verilog/spram.sv */
// banked single-port memory built from fixed-size soft banks
module spram #(
    parameter int bank_aw = 6  // address bits inside one bank
) (
    input  logic             clk,
    input  logic             ce,
    input  logic             we,
    input  spram_pkg::data_t wmask,
    input  spram_pkg::addr_t addr,
    input  spram_pkg::data_t din,
    output spram_pkg::data_t dout
);

    localparam int sel_w   = spram_pkg::aw - bank_aw;
    localparam int n_banks = 2 ** sel_w;

    generate
        if (n_banks == 1) begin : g_single
            // whole address space fits one bank
            spram_bank #(
                .bank_aw (bank_aw)
            ) u_bank (
                .clk   (clk),
                .ce    (ce),
                .we    (we),
                .wmask (wmask),
                .addr  (addr[bank_aw-1:0]),
                .din   (din),
                .dout  (dout)
            );
        end else begin : g_banked
            logic [sel_w-1:0]   sel;      // bank addressed this cycle
            logic [sel_w-1:0]   sel_q;    // bank of the last read
            logic [bank_aw-1:0] bank_addr;
            spram_pkg::data_t   gated [n_banks];

            assign sel       = addr[spram_pkg::aw-1:bank_aw];
            assign bank_addr = addr[bank_aw-1:0];

            // follows the read so the mux lines up with dout of that bank
            always_ff @(posedge clk) begin
                if (ce && !we) begin
                    sel_q <= sel;
                end
            end

            for (genvar b = 0; b < n_banks; b++) begin : g_bank
                logic             hit;
                spram_pkg::data_t bank_dout;

                assign hit = (sel == sel_w'(b));

                spram_bank #(
                    .bank_aw (bank_aw)
                ) u_bank (
                    .clk   (clk),
                    .ce    (ce && hit),  // only the addressed bank toggles
                    .we    (we && hit),
                    .wmask (wmask),
                    .addr  (bank_addr),
                    .din   (din),
                    .dout  (bank_dout)
                );

                assign gated[b] = (sel_q == sel_w'(b)) ? bank_dout : '0;
            end

            // at most one gated output is nonzero
            always_comb begin
                dout = '0;
                for (int b = 0; b < n_banks; b++) begin
                    dout = dout | gated[b];
                end
            end
        end
    endgenerate

endmodule

/* verilog/spram_bank.sv */
// soft single-port bank with per-bit write mask and one cycle read latency
module spram_bank #(
    parameter int bank_aw = 6
) (
    input  logic               clk,
    input  logic               ce,     // chip enable
    input  logic               we,     // write enable
    input  spram_pkg::data_t   wmask,  // 1 = write this bit
    input  logic [bank_aw-1:0] addr,
    input  spram_pkg::data_t   din,
    output spram_pkg::data_t   dout
);

    localparam int words = 2 ** bank_aw;

    spram_pkg::data_t mem [words];

    // masked write, bits with a clear mask keep their old value
    always_ff @(posedge clk) begin
        if (ce && we) begin
            mem[addr] <= (mem[addr] & ~wmask) | (din & wmask);
        end
    end

    // registered read, dout holds between reads
    always_ff @(posedge clk) begin
        if (ce && !we) begin
            dout <= mem[addr];
        end
    end

endmodule

/* verilog/spram_pkg.sv */
// data and address widths, their vector types and the request entry width
package spram_pkg;

    localparam int dw = 32;  // data word width
    localparam int aw = 8;   // word address width, 256 words total

    typedef logic [dw-1:0] data_t;  // data word or per-bit write mask
    typedef logic [aw-1:0] addr_t;  // word address

    // request queue entry, msb first: we, addr, wmask, wdata
    localparam int req_w = 1 + aw + 2 * dw;

endpackage

/* verilog/spram_sys.sv */
// top level joining request queue, controller, banked memory and response queue
module spram_sys #(
    parameter int req_depth   = 4,
    parameter int rsp_depth   = 4,
    parameter int rsp_credits = 2,
    parameter int bank_aw     = 6
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             req_valid,
    input  logic             req_we,
    input  spram_pkg::addr_t req_addr,
    input  spram_pkg::data_t req_wmask,
    input  spram_pkg::data_t req_wdata,
    input  logic             rsp_credit,
    output logic             req_credit,
    output logic             rsp_valid,
    output spram_pkg::data_t rsp_data
);

    logic [spram_pkg::req_w-1:0]    req_entry;
    logic [spram_pkg::req_w-1:0]    req_head;
    logic                           req_empty;
    logic                           req_pop;
    logic                           rsp_push;
    logic                           rsp_pop;
    logic                           rsp_empty;
    logic [$clog2(rsp_depth+1)-1:0] rsp_count;
    logic                           mem_ce;
    logic                           mem_we;
    spram_pkg::addr_t               mem_addr;
    spram_pkg::data_t               mem_wmask;
    spram_pkg::data_t               mem_din;
    spram_pkg::data_t               mem_dout;

    assign req_entry = {req_we, req_addr, req_wmask, req_wdata};  // same order mem_ctrl unpacks

    sync_fifo #(
        .depth (req_depth),
        .width (spram_pkg::req_w)
    ) u_req_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (req_valid),  // credits keep the requester from overflowing it
        .push_data (req_entry),
        .pop       (req_pop),
        .pop_data  (req_head),
        .empty     (req_empty),
        .full      (),
        .count     ()
    );

    mem_ctrl #(
        .rsp_depth   (rsp_depth),
        .rsp_credits (rsp_credits)
    ) u_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .head       (req_head),
        .req_empty  (req_empty),
        .rsp_count  (rsp_count),
        .rsp_empty  (rsp_empty),
        .rsp_credit (rsp_credit),
        .req_pop    (req_pop),
        .req_credit (req_credit),
        .mem_ce     (mem_ce),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wmask  (mem_wmask),
        .mem_din    (mem_din),
        .rsp_push   (rsp_push),
        .rsp_pop    (rsp_pop),
        .rsp_valid  (rsp_valid)
    );

    spram #(
        .bank_aw (bank_aw)
    ) u_mem (
        .clk   (clk),
        .ce    (mem_ce),
        .we    (mem_we),
        .wmask (mem_wmask),
        .addr  (mem_addr),
        .din   (mem_din),
        .dout  (mem_dout)
    );

    sync_fifo #(
        .depth (rsp_depth),
        .width (spram_pkg::dw)
    ) u_rsp_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (rsp_push),
        .push_data (mem_dout),
        .pop       (rsp_pop),
        .pop_data  (rsp_data),  // head goes out with rsp_valid
        .empty     (rsp_empty),
        .full      (),
        .count     (rsp_count)
    );

endmodule

/* verilog/sync_fifo.sv */
// synchronous first-word-fall-through FIFO with parameterized depth and width
module sync_fifo #(
    parameter int depth = 4,
    parameter int width = 8
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       push,
    input  logic [width-1:0]           push_data,
    input  logic                       pop,
    output logic [width-1:0]           pop_data,
    output logic                       empty,
    output logic                       full,
    output logic [$clog2(depth+1)-1:0] count
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;

    // wraps at depth, so depth need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or push with pop
            endcase
        end
    end

    assign pop_data = mem[rd_ptr];  // head is visible without a pop
    assign empty    = (count == '0);
    assign full     = (count == cnt_w'(depth));

endmodule
